// ==== include/sys_ctrl_params.svh ====
`ifndef SYS_CTRL_PARAMS_SVH
`define SYS_CTRL_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// interrupt descriptor table
//////////////////////////////////////////////////////////////////////

// vector word location for each interrupt line
`define SYS_IDT_ADDRESS0 32'h0000_4000
`define SYS_IDT_ADDRESS1 32'h0000_8000
`define SYS_IDT_ADDRESS2 32'h0000_c000
`define SYS_IDT_ADDRESS3 32'h0000_f000

// hardware interrupt request lines
`define SYS_NUM_INT 4

`endif

// ==== hdl/sys_ctrl_pkg.sv ====
`include "sys_ctrl_params.svh"

package sys_ctrl_pkg;

  // address or data word
  typedef logic [31:0] addr_t;

  // code segment selector
  typedef logic [15:0] seg_t;

  typedef logic [`SYS_NUM_INT-1:0]         int_vec_t;
  typedef logic [$clog2(`SYS_NUM_INT)-1:0] int_idx_t;

  // bit 0 fetch, then decode_0, decode_1, register, address, execute,
  // bit 6 writeback
  typedef logic [6:0] flush_vec_t;

  typedef enum logic [2:0] {
    INT_IDLE,
    INT_VEC_REQ,
    INT_VEC_WAIT,
    INT_REDIRECT,
    INT_ENTRY
  } int_state_e;

  typedef enum logic [1:0] {
    IRET_IDLE,
    IRET_POP_EIP,
    IRET_POP_CS,
    IRET_POP_EFLAGS
  } iretd_state_e;

endpackage

// ==== hdl/ctrl_redirect_if.sv ====
`timescale 1ns/10ps

interface ctrl_redirect_if import sys_ctrl_pkg::*; ();

  flush_vec_t flush;

  logic       fetch_load;
  addr_t      fetch_load_address;

  // value fields are zero whenever their strobe is low
  logic       reg_load_eip;
  addr_t      reg_eip;
  logic       reg_load_cs;
  seg_t       reg_cs;
  logic       reg_load_eflags;
  addr_t      reg_eflags;

  modport src (
    output flush,
    output fetch_load, fetch_load_address,
    output reg_load_eip, reg_eip,
    output reg_load_cs, reg_cs,
    output reg_load_eflags, reg_eflags
  );

  modport merge (
    input flush,
    input fetch_load, fetch_load_address,
    input reg_load_eip, reg_eip,
    input reg_load_cs, reg_cs,
    input reg_load_eflags, reg_eflags
  );

endinterface

// ==== hdl/int_latch.sv ====
`timescale 1ns/10ps
`include "sys_ctrl_params.svh"

module int_latch import sys_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  int_vec_t int_vec,
  input  logic     int_clear,
  output logic     int_pending,
  output int_idx_t int_serviced
);

  int_vec_t pend_q;
  int_vec_t clear_mask;

  // lowest numbered pending line wins
  always_comb begin
    int_serviced = '0;
    for (int i = `SYS_NUM_INT - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        int_serviced = int_idx_t'(i);
      end
    end
  end

  always_comb begin
    clear_mask = '0;
    clear_mask[int_serviced] = int_clear;
  end

  // clear wins over a line still held high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q | int_vec) & ~clear_mask;
    end
  end

  assign int_pending = |pend_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // controller only clears what it has been servicing
  a_clear_pending : assert property (
    @(posedge clk) disable iff (!rst_n) int_clear |-> int_pending
  ) else $error("int_clear with nothing pending");

endmodule

// ==== hdl/int_controller.sv ====
`timescale 1ns/10ps
`include "sys_ctrl_params.svh"

module int_controller import sys_ctrl_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            int_pending,
  input  int_idx_t        int_serviced,
  input  logic            iretd_busy,
  output logic            mem_valid,
  input  logic            mem_ready,
  output addr_t           mem_address,
  input  logic            mem_dp_valid,
  output logic            mem_dp_ready,
  input  addr_t           mem_dp_read_data,
  output logic            decode_start_int,
  input  logic            decode_end_int,
  output logic            int_clear,
  ctrl_redirect_if.src    redir
);

  int_state_e state_q;
  int_state_e state_d;
  int_idx_t   idx_q;
  addr_t      vec_q;
  logic       redirect;

  always_comb begin
    state_d = state_q;
    case (state_q)
      INT_IDLE:     if (int_pending && !iretd_busy) state_d = INT_VEC_REQ;
      INT_VEC_REQ:  if (mem_ready) state_d = INT_VEC_WAIT;
      INT_VEC_WAIT: if (mem_dp_valid) state_d = INT_REDIRECT;
      INT_REDIRECT: state_d = INT_ENTRY;
      INT_ENTRY:    if (decode_end_int) state_d = INT_IDLE;
      default:      state_d = INT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= INT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // index frozen on leaving idle so the address holds under wait states
  always_ff @(posedge clk) begin
    if (state_q == INT_IDLE) begin
      idx_q <= int_serviced;
    end
    if (state_q == INT_VEC_WAIT && mem_dp_valid) begin
      vec_q <= mem_dp_read_data;
    end
  end

  always_comb begin
    case (idx_q)
      2'd0:    mem_address = `SYS_IDT_ADDRESS0;
      2'd1:    mem_address = `SYS_IDT_ADDRESS1;
      2'd2:    mem_address = `SYS_IDT_ADDRESS2;
      default: mem_address = `SYS_IDT_ADDRESS3;
    endcase
  end

  assign mem_valid    = (state_q == INT_VEC_REQ);
  assign mem_dp_ready = (state_q == INT_VEC_WAIT);

  //////////////////////////////////////////////////////////////////////
  // redirect to the vector, one cycle
  //////////////////////////////////////////////////////////////////////

  assign redirect         = (state_q == INT_REDIRECT);
  assign decode_start_int = redirect;
  assign int_clear        = redirect;

  assign redir.flush              = redirect ? '1 : '0;
  assign redir.fetch_load         = redirect;
  assign redir.fetch_load_address = redirect ? vec_q : '0;

  // entry microcode handles the register state
  assign redir.reg_load_eip    = 1'b0;
  assign redir.reg_eip         = '0;
  assign redir.reg_load_cs     = 1'b0;
  assign redir.reg_cs          = '0;
  assign redir.reg_load_eflags = 1'b0;
  assign redir.reg_eflags      = '0;

  a_addr_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_address)
  ) else $error("mem_address changed before request accepted");

  a_redirect_once : assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q == INT_REDIRECT |=> state_q != INT_REDIRECT
  ) else $error("redirect held longer than one cycle");

endmodule

// ==== hdl/iretd_sequencer.sv ====
`timescale 1ns/10ps

module iretd_sequencer import sys_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         iretd,
  output logic         iretd_halt,
  output logic         iretd_busy,
  input  logic         iretd_pop_valid,
  input  addr_t        iretd_pop_data,
  ctrl_redirect_if.src redir
);

  iretd_state_e state_q;
  iretd_state_e state_d;
  addr_t        eip_q;
  seg_t         cs_q;
  addr_t        ret_address;
  logic         pop_eip;
  logic         pop_cs;
  logic         pop_eflags;

  assign pop_eip    = (state_q == IRET_POP_EIP) && iretd_pop_valid;
  assign pop_cs     = (state_q == IRET_POP_CS) && iretd_pop_valid;
  assign pop_eflags = (state_q == IRET_POP_EFLAGS) && iretd_pop_valid;

  // no pop means the stack is not ready yet, so hold
  always_comb begin
    state_d = state_q;
    case (state_q)
      IRET_IDLE:       if (iretd) state_d = IRET_POP_EIP;
      IRET_POP_EIP:    if (pop_eip) state_d = IRET_POP_CS;
      IRET_POP_CS:     if (pop_cs) state_d = IRET_POP_EFLAGS;
      IRET_POP_EFLAGS: if (pop_eflags) state_d = IRET_IDLE;
      default:         state_d = IRET_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IRET_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_eip) eip_q <= iretd_pop_data;
    if (pop_cs) cs_q <= iretd_pop_data[15:0];
  end

  // return target is cs base plus eip
  assign ret_address = addr_t'(cs_q) + eip_q;

  assign iretd_halt = (state_q != IRET_IDLE);
  assign iretd_busy = iretd_halt || iretd;

  // only fetch is held off, the older instructions drain
  assign redir.flush = {6'b0, iretd_halt};

  assign redir.fetch_load         = pop_eflags;
  assign redir.fetch_load_address = pop_eflags ? ret_address : '0;
  assign redir.reg_load_eip       = pop_eip;
  assign redir.reg_eip            = pop_eip ? iretd_pop_data : '0;
  assign redir.reg_load_cs        = pop_cs;
  assign redir.reg_cs             = pop_cs ? iretd_pop_data[15:0] : '0;
  assign redir.reg_load_eflags    = pop_eflags;
  assign redir.reg_eflags         = pop_eflags ? iretd_pop_data : '0;

endmodule

// ==== hdl/ctrl_merge.sv ====
`timescale 1ns/10ps

module ctrl_merge import sys_ctrl_pkg::*; (
  ctrl_redirect_if.merge int_src,
  ctrl_redirect_if.merge ret_src,
  output logic           flush_fetch,
  output logic           flush_decode_0,
  output logic           flush_decode_1,
  output logic           flush_register,
  output logic           flush_address,
  output logic           flush_execute,
  output logic           flush_writeback,
  output logic           fetch_load,
  output addr_t          fetch_load_address,
  output logic           reg_load_eip,
  output addr_t          reg_eip,
  output logic           reg_load_cs,
  output seg_t           reg_cs,
  output logic           reg_load_eflags,
  output addr_t          reg_eflags
);

  flush_vec_t flush;

  assign flush           = int_src.flush | ret_src.flush;
  assign flush_fetch     = flush[0];
  assign flush_decode_0  = flush[1];
  assign flush_decode_1  = flush[2];
  assign flush_register  = flush[3];
  assign flush_address   = flush[4];
  assign flush_execute   = flush[5];
  assign flush_writeback = flush[6];

  assign fetch_load         = int_src.fetch_load | ret_src.fetch_load;
  assign fetch_load_address = ret_src.fetch_load ? ret_src.fetch_load_address
                                                 : int_src.fetch_load_address;

  // sources zero their values when idle, so a plain or is enough
  assign reg_load_eip    = int_src.reg_load_eip | ret_src.reg_load_eip;
  assign reg_eip         = int_src.reg_eip | ret_src.reg_eip;
  assign reg_load_cs     = int_src.reg_load_cs | ret_src.reg_load_cs;
  assign reg_cs          = int_src.reg_cs | ret_src.reg_cs;
  assign reg_load_eflags = int_src.reg_load_eflags | ret_src.reg_load_eflags;
  assign reg_eflags      = int_src.reg_eflags | ret_src.reg_eflags;

  always_comb begin
    a_one_fetch_load : assert final (!(int_src.fetch_load && ret_src.fetch_load))
      else $error("interrupt and iretd both load fetch");
  end

endmodule

// ==== hdl/sys_ctrl_top.sv ====
`timescale 1ns/10ps

module sys_ctrl_top import sys_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  int_vec_t int_vec,
  output logic     mem_valid,
  input  logic     mem_ready,
  output addr_t    mem_address,
  input  logic     mem_dp_valid,
  output logic     mem_dp_ready,
  input  addr_t    mem_dp_read_data,
  output logic     flush_fetch,
  output logic     flush_decode_0,
  output logic     flush_decode_1,
  output logic     flush_register,
  output logic     flush_address,
  output logic     flush_execute,
  output logic     flush_writeback,
  output logic     fetch_load,
  output addr_t    fetch_load_address,
  output logic     decode_start_int,
  input  logic     decode_end_int,
  output logic     reg_load_cs,
  output seg_t     reg_cs,
  input  logic     iretd,
  output logic     iretd_halt,
  input  logic     iretd_pop_valid,
  input  addr_t    iretd_pop_data,
  output logic     reg_load_eflags,
  output addr_t    reg_eflags,
  output logic     reg_load_eip,
  output addr_t    reg_eip
);

  logic     int_pending;
  int_idx_t int_serviced;
  logic     int_clear;
  logic     iretd_busy;

  ctrl_redirect_if int_redir ();
  ctrl_redirect_if ret_redir ();

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  int_latch i_int_latch (
    .clk          (clk),
    .rst_n        (rst_n),
    .int_vec      (int_vec),
    .int_clear    (int_clear),
    .int_pending  (int_pending),
    .int_serviced (int_serviced)
  );

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  int_controller i_int_controller (
    .clk              (clk),
    .rst_n            (rst_n),
    .int_pending      (int_pending),
    .int_serviced     (int_serviced),
    .iretd_busy       (iretd_busy),
    .mem_valid        (mem_valid),
    .mem_ready        (mem_ready),
    .mem_address      (mem_address),
    .mem_dp_valid     (mem_dp_valid),
    .mem_dp_ready     (mem_dp_ready),
    .mem_dp_read_data (mem_dp_read_data),
    .decode_start_int (decode_start_int),
    .decode_end_int   (decode_end_int),
    .int_clear        (int_clear),
    .redir            (int_redir)
  );

  iretd_sequencer i_iretd_sequencer (
    .clk             (clk),
    .rst_n           (rst_n),
    .iretd           (iretd),
    .iretd_halt      (iretd_halt),
    .iretd_busy      (iretd_busy),
    .iretd_pop_valid (iretd_pop_valid),
    .iretd_pop_data  (iretd_pop_data),
    .redir           (ret_redir)
  );

  ctrl_merge i_ctrl_merge (
    .int_src            (int_redir),
    .ret_src            (ret_redir),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute),
    .flush_writeback    (flush_writeback),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags)
  );

endmodule

// ==== bench/sys_ctrl_tb.sv ====
`timescale 1ns/10ps
`include "sys_ctrl_params.svh"

module sys_ctrl_tb import sys_ctrl_pkg::*; ();

  localparam int NUM_OPS     = 60;
  localparam int CYCLE_LIMIT = 200 * NUM_OPS;

  logic     clk;
  logic     rst_n;
  int_vec_t int_vec;
  logic     mem_valid;
  logic     mem_ready = 1'b0;
  addr_t    mem_address;
  logic     mem_dp_valid = 1'b0;
  logic     mem_dp_ready;
  addr_t    mem_dp_read_data = '0;
  logic     flush_fetch;
  logic     flush_decode_0;
  logic     flush_decode_1;
  logic     flush_register;
  logic     flush_address;
  logic     flush_execute;
  logic     flush_writeback;
  logic     fetch_load;
  addr_t    fetch_load_address;
  logic     decode_start_int;
  logic     decode_end_int = 1'b0;
  logic     reg_load_cs;
  seg_t     reg_cs;
  logic     iretd;
  logic     iretd_halt;
  logic     iretd_pop_valid = 1'b0;
  addr_t    iretd_pop_data = '0;
  logic     reg_load_eflags;
  addr_t    reg_eflags;
  logic     reg_load_eip;
  addr_t    reg_eip;

  integer   seed = 32'hc823;
  int       errors = 0;
  int       cycles = 0;
  addr_t    vec_table [4];
  addr_t    stack_word [3];

  // model state
  int_vec_t exp_pend = '0;
  int_vec_t clr_next = '0;
  logic     in_svc = 1'b0;
  logic     in_entry = 1'b0;
  int_idx_t svc_idx = '0;
  logic     ret_active = 1'b0;
  int       ret_step = 0;
  int       rdy_wait = 0;
  int       dp_wait = 0;
  int       dec_wait = 0;
  addr_t    req_addr = '0;
  logic [1:0] stk_cnt = '0;

  sys_ctrl_top i_dut (.*);

  function automatic int rand_below(int n);
    rand_below = int'($unsigned($random(seed)) % n);
  endfunction

  function automatic addr_t rand_word();
    rand_word = addr_t'($random(seed));
  endfunction

  function automatic addr_t idt_address(int_idx_t idx);
    case (idx)
      2'd0:    idt_address = `SYS_IDT_ADDRESS0;
      2'd1:    idt_address = `SYS_IDT_ADDRESS1;
      2'd2:    idt_address = `SYS_IDT_ADDRESS2;
      default: idt_address = `SYS_IDT_ADDRESS3;
    endcase
  endfunction

  // isolate the lowest set bit, then name it
  function automatic int_idx_t lowest_pending(int_vec_t v);
    int_vec_t low;
    low = v & (~v + int_vec_t'(1));
    case (low)
      4'b0010: lowest_pending = 2'd1;
      4'b0100: lowest_pending = 2'd2;
      4'b1000: lowest_pending = 2'd3;
      default: lowest_pending = 2'd0;
    endcase
  endfunction

  function automatic addr_t mem_word(addr_t a);
    case (a)
      `SYS_IDT_ADDRESS0: mem_word = vec_table[0];
      `SYS_IDT_ADDRESS1: mem_word = vec_table[1];
      `SYS_IDT_ADDRESS2: mem_word = vec_table[2];
      `SYS_IDT_ADDRESS3: mem_word = vec_table[3];
      default:           mem_word = ~a;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d errors", cycles, errors);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory, decode and stack models
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!mem_valid) begin
      rdy_wait = rand_below(4);
      mem_ready <= 1'b0;
    end else if (rdy_wait == 0) begin
      mem_ready <= 1'b1;
      req_addr = mem_address;
      dp_wait  = rand_below(4);
    end else begin
      rdy_wait--;
    end
    if (mem_dp_ready && dp_wait == 0) begin
      mem_dp_valid     <= 1'b1;
      mem_dp_read_data <= mem_word(req_addr);
    end else begin
      mem_dp_valid     <= 1'b0;
      mem_dp_read_data <= rand_word();
      if (mem_dp_ready) dp_wait--;
    end
  end

  always @(negedge clk) begin
    decode_end_int <= 1'b0;
    if (dec_wait > 0) begin
      dec_wait--;
      if (dec_wait == 0) decode_end_int <= 1'b1;
    end
    if (decode_start_int) dec_wait = 1 + rand_below(4);
  end

  // pops eip, cs, eflags with random gaps
  always @(negedge clk) begin
    if (!iretd_halt) begin
      stk_cnt = '0;
      iretd_pop_valid <= 1'b0;
    end else if (stk_cnt < 2'd3 && rand_below(3) != 0) begin
      iretd_pop_valid <= 1'b1;
      iretd_pop_data  <= stack_word[stk_cnt];
      stk_cnt++;
    end else begin
      iretd_pop_valid <= 1'b0;
      iretd_pop_data  <= rand_word();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // monitor and reference model
  //////////////////////////////////////////////////////////////////////

  // values seen here belong to the cycle that ends at this edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (mem_valid && !in_svc) begin
        if (exp_pend == '0) report_error("interrupt serviced with nothing pending");
        if (in_entry) report_error("interrupt started before decode_end_int");
        if (ret_active) report_error("interrupt started during iretd");
        in_svc = 1'b1;
      end else if (!in_svc) begin
        // line picked in the last idle cycle
        svc_idx = lowest_pending(exp_pend);
      end
      if (mem_valid) check_value("mem_address", mem_address, idt_address(svc_idx));
      if (decode_start_int) begin
        if (!in_svc) report_error("interrupt redirect without a vector read");
        check_value("fetch_load", 32'(fetch_load), 32'd1);
        check_value("flush", 32'({flush_writeback, flush_execute, flush_address,
                                  flush_register, flush_decode_1, flush_decode_0,
                                  flush_fetch}), 32'h7f);
        check_value("fetch_load_address", fetch_load_address, vec_table[svc_idx]);
        clr_next[svc_idx] = 1'b1;
        in_svc   = 1'b0;
        in_entry = 1'b1;
      end else if (in_entry && decode_end_int) begin
        in_entry = 1'b0;
      end

      if (ret_active && ret_step < 3) begin
        check_value("iretd_halt", 32'(iretd_halt), 32'd1);
        check_value("flush_fetch", 32'(flush_fetch), 32'd1);
      end
      if (iretd) begin
        if (ret_active) report_error("iretd while a return is running");
        ret_active = 1'b1;
        ret_step   = 0;
      end
      if (reg_load_eip) begin
        if (!ret_active || ret_step != 0) report_error("eip loaded out of order");
        check_value("reg_eip", reg_eip, stack_word[0]);
        ret_step = 1;
      end
      if (reg_load_cs) begin
        if (ret_step != 1) report_error("cs loaded out of order");
        check_value("reg_cs", 32'(reg_cs), 32'(stack_word[1][15:0]));
        ret_step = 2;
      end
      if (reg_load_eflags) begin
        if (ret_step != 2) report_error("eflags loaded out of order");
        check_value("reg_eflags", reg_eflags, stack_word[2]);
        check_value("fetch_load", 32'(fetch_load), 32'd1);
        check_value("fetch_load_address", fetch_load_address,
                    {16'h0000, stack_word[1][15:0]} + stack_word[0]);
        ret_step = 3;
      end else if (ret_step == 3) begin
        check_value("iretd_halt", 32'(iretd_halt), 32'd0);
        ret_active = 1'b0;
        ret_step   = 0;
      end

      if (decode_start_int && reg_load_eflags) report_error("two fetch loads in one cycle");
      if (fetch_load && !decode_start_int && !reg_load_eflags) begin
        report_error("fetch_load with no source");
      end
      // nothing in flight, so the control outputs rest low
      if (exp_pend == '0 && !in_svc && !in_entry && !ret_active) begin
        check_value("idle outputs", 32'({mem_valid, mem_dp_ready, decode_start_int,
                                         iretd_halt, fetch_load, reg_load_eip,
                                         reg_load_cs, reg_load_eflags, flush_fetch,
                                         flush_decode_0, flush_decode_1, flush_register,
                                         flush_address, flush_execute,
                                         flush_writeback}), 32'd0);
      end

      // pending lines from this edge on
      exp_pend = (exp_pend | int_vec) & ~clr_next;
      clr_next = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int       kind;
    int_vec_t lines;
    rst_n   = 1'b0;
    int_vec = '0;
    iretd   = 1'b0;
    vec_table[0] = rand_word();
    vec_table[1] = rand_word();
    vec_table[2] = rand_word();
    vec_table[3] = rand_word();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    repeat (2) @(negedge clk);
    for (int op = 0; op < NUM_OPS; op++) begin
      // 0 interrupts, 1 iretd, 2 both in the same cycle
      kind  = rand_below(3);
      lines = int_vec_t'(1 + rand_below(15));
      stack_word[0] = rand_word();
      stack_word[1] = rand_word();
      stack_word[2] = rand_word();
      @(negedge clk);
      if (kind != 1) int_vec <= lines;
      if (kind != 0) iretd <= 1'b1;
      @(negedge clk);
      int_vec <= '0;
      iretd   <= 1'b0;
      @(negedge clk);
      while (exp_pend != '0 || in_svc || in_entry || ret_active) begin
        // lines still pending are raised again now and then
        if (in_svc && rand_below(2) == 0) begin
          int_vec <= exp_pend & int_vec_t'(rand_below(16));
        end else begin
          int_vec <= '0;
        end
        @(negedge clk);
      end
      int_vec <= '0;
      repeat (rand_below(3)) @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("%0d operations, %0d errors", NUM_OPS, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
hdl/sys_ctrl_pkg.sv
hdl/ctrl_redirect_if.sv
hdl/int_latch.sv
hdl/int_controller.sv
hdl/iretd_sequencer.sv
hdl/ctrl_merge.sv
hdl/sys_ctrl_top.sv
bench/sys_ctrl_tb.sv

// ==== Makefile ====
TOP = sys_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f src.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log || (echo "no pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
